// ==== logic/soc_map_pkg.sv ====
// ---------------------------------------------------------------------
// Memory map and bus types of the harness store. Both words of the
// control window alias one register. DRAM ends at NumWords words,
// which the top level sets.
// ---------------------------------------------------------------------
package soc_map_pkg;

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned ByteOffset = 3;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] be_t;

  typedef enum logic [1:0] {
    RegionRom  = 2'd0,
    RegionCtrl = 2'd1,
    RegionDram = 2'd2,
    RegionNone = 2'd3
  } region_e;

  localparam addr_t RomBase    = 32'h0001_0000;
  localparam addr_t RomLength  = 32'h0000_1000;
  localparam addr_t CtrlBase   = 32'h0200_0000;
  localparam addr_t CtrlLength = 32'h0000_0010;
  localparam addr_t DramBase   = 32'h8000_0000;

  // Word index into the ROM window
  localparam int unsigned RomIdxWidth = $clog2(RomLength >> ByteOffset);

  localparam data_t BootImage [8] = '{
    64'h0000_0517_f140_2573, 64'h0205_0513_0010_059b,
    64'h0000_0297_01f5_9593, 64'h0182_b283_00b5_0533,
    64'h1050_0073_0002_8067, 64'h0000_0000_ffdf_f06f,
    64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001
  };

  // Bit positions in control word 0
  localparam int unsigned CtrlDebugEnBit = 0;
  localparam int unsigned CtrlSrcJtagBit = 1;

endpackage

// ==== logic/dmi_pkg.sv ====
// ---------------------------------------------------------------------
// Debug module interface types. Field widths follow the DMI of the
// RISC-V debug spec with a 7-bit register address.
// ---------------------------------------------------------------------
package dmi_pkg;

  typedef enum logic [1:0] {
    DmiNop   = 2'd0,
    DmiRead  = 2'd1,
    DmiWrite = 2'd2
  } dmi_op_e;

  typedef struct packed {
    logic [6:0]  addr;
    dmi_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  // 0 ok, 2 failed, 3 busy
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

endpackage

// ==== logic/boot_rom.sv ====
// ---------------------------------------------------------------------
// Boot ROM with registered read. Only the first eight words hold code,
// the rest of the window reads zero.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module boot_rom import soc_map_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rom_req_i,
  input  logic [RomIdxWidth-1:0] rom_idx_i,
  output data_t                  rom_rdata_o
);

  localparam int unsigned ImageWords = $size(BootImage);

  // Read data holds its value between requests
  always_ff @(posedge clk_i) begin
    if (rom_req_i) begin
      if (rom_idx_i < ImageWords) begin
        rom_rdata_o <= BootImage[rom_idx_i[$clog2(ImageWords)-1:0]];
      end else begin
        rom_rdata_o <= '0;
      end
    end
  end

endmodule

// ==== logic/sram_bank.sv ====
// ---------------------------------------------------------------------
// Single-port word SRAM with byte enables. Read data is registered
// and is left unchanged by writes.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module sram_bank import soc_map_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] idx_i,
  input  be_t                         be_i,
  input  data_t                       wdata_i,
  output data_t                       rdata_o
);

  data_t mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DataWidth / 8; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

  // Decoder must keep DRAM accesses inside the array
  a_idx_in_range: assert property (@(posedge clk_i) req_i |-> idx_i < NumWords);

endmodule

// ==== logic/harness_ctrl_regs.sv ====
// ---------------------------------------------------------------------
// Run-time control word: debug enable and DMI source select. Only
// byte 0 is writable, all other read bits are zero.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module harness_ctrl_regs import soc_map_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output data_t rdata_o,
  output logic  debug_en_o,
  output logic  src_jtag_o
);

  logic debug_en_q, src_jtag_q;

  // Debug enabled and DTM selected out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      debug_en_q <= 1'b1;
      src_jtag_q <= 1'b0;
    end else if (req_i && we_i && be_i[0]) begin
      debug_en_q <= wdata_i[CtrlDebugEnBit];
      src_jtag_q <= wdata_i[CtrlSrcJtagBit];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o                 <= '0;
      rdata_o[CtrlDebugEnBit] <= debug_en_q;
      rdata_o[CtrlSrcJtagBit] <= src_jtag_q;
    end
  end

  assign debug_en_o = debug_en_q;
  assign src_jtag_o = src_jtag_q;

endmodule

// ==== logic/bus_decoder.sv ====
// ---------------------------------------------------------------------
// Address decode for ROM, control block and DRAM. Anything else, a ROM
// write or DRAM past NumWords words answers with err and zero data.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module bus_decoder import soc_map_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         mem_req_i,
  input  logic                         mem_we_i,
  input  addr_t                        mem_addr_i,
  input  be_t                          mem_be_i,
  input  data_t                        mem_wdata_i,
  input  data_t                        rom_rdata_i,
  input  data_t                        sram_rdata_i,
  input  data_t                        ctrl_rdata_i,
  output logic                         rom_req_o,
  output logic [RomIdxWidth-1:0]       rom_idx_o,
  output logic                         sram_req_o,
  output logic                         sram_we_o,
  output logic [$clog2(NumWords)-1:0]  sram_idx_o,
  output be_t                          sram_be_o,
  output data_t                        sram_wdata_o,
  output logic                         ctrl_req_o,
  output logic                         ctrl_we_o,
  output be_t                          ctrl_be_o,
  output data_t                        ctrl_wdata_o,
  output data_t                        mem_rdata_o,
  output logic                         mem_rvalid_o,
  output logic                         mem_err_o
);

  localparam int unsigned SramIdxWidth = $clog2(NumWords);

  region_e region, region_q;
  addr_t   dram_off;
  logic    err;
  logic    valid_q, err_q, rd_q;
  data_t   rdata_sel;

  assign dram_off = mem_addr_i - DramBase;

  always_comb begin
    region = RegionNone;
    if (mem_addr_i >= RomBase && mem_addr_i < RomBase + RomLength) begin
      region = RegionRom;
    end else if (mem_addr_i >= CtrlBase && mem_addr_i < CtrlBase + CtrlLength) begin
      region = RegionCtrl;
    end else if (mem_addr_i >= DramBase && (dram_off >> ByteOffset) < NumWords) begin
      region = RegionDram;
    end
  end

  assign err = (region == RegionNone) || (region == RegionRom && mem_we_i);

  // Only the selected target sees a request
  assign rom_req_o    = mem_req_i && region == RegionRom && !mem_we_i;
  assign rom_idx_o    = mem_addr_i[ByteOffset +: RomIdxWidth];
  assign sram_req_o   = mem_req_i && region == RegionDram;
  assign sram_we_o    = mem_we_i;
  assign sram_idx_o   = dram_off[ByteOffset +: SramIdxWidth];
  assign sram_be_o    = mem_be_i;
  assign sram_wdata_o = mem_wdata_i;
  assign ctrl_req_o   = mem_req_i && region == RegionCtrl;
  assign ctrl_we_o    = mem_we_i;
  assign ctrl_be_o    = mem_be_i;
  assign ctrl_wdata_o = mem_wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      rd_q    <= 1'b0;
    end else begin
      valid_q <= mem_req_i;
      err_q   <= mem_req_i && err;
      rd_q    <= mem_req_i && !mem_we_i && !err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      region_q <= region;
    end
  end

  // Writes and errors return zero data
  always_comb begin
    case (region_q)
      RegionRom:  rdata_sel = rom_rdata_i;
      RegionCtrl: rdata_sel = ctrl_rdata_i;
      RegionDram: rdata_sel = sram_rdata_i;
      default:    rdata_sel = '0;
    endcase
  end

  assign mem_rdata_o  = rd_q ? rdata_sel : '0;
  assign mem_rvalid_o = valid_q;
  assign mem_err_o    = err_q;

  // Request fields must be known for the decode
  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |-> !$isunknown({mem_we_i, mem_addr_i}));

endmodule

// ==== logic/debug_gate.sv ====
// ---------------------------------------------------------------------
// Holds the core debug request low for DmiDelCycles clocks after reset
// so boot code runs undisturbed, then passes it while debug is enabled.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module debug_gate #(
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_en_i,
  input  logic debug_req_core_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(DmiDelCycles + 1);

  logic [CntWidth-1:0] cnt_q;

  // Hold-off counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DmiDelCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_en_i && debug_req_core_i;

endmodule

// ==== logic/dmi_source_mux.sv ====
// ---------------------------------------------------------------------
// Shares one DMI port between the JTAG and DTM sources. The debug
// module must keep at most one request in flight; the source only
// switches once that request has its response.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module dmi_source_mux import dmi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        src_jtag_i,
  input  logic        jtag_req_valid_i,
  input  dmi_req_t    jtag_req_i,
  input  logic        jtag_resp_ready_i,
  input  logic [31:0] jtag_exit_i,
  output logic        jtag_resp_valid_o,
  input  logic        dtm_req_valid_i,
  input  dmi_req_t    dtm_req_i,
  input  logic        dtm_resp_ready_i,
  input  logic [31:0] dtm_exit_i,
  output logic        dtm_resp_valid_o,
  input  logic        dm_req_ready_i,
  input  logic        dm_resp_valid_i,
  output logic        dm_req_valid_o,
  output dmi_req_t    dm_req_o,
  output logic        dm_resp_ready_o,
  output logic [31:0] exit_o
);

  logic active_jtag_q;
  logic outstanding_q, outstanding_d;
  logic req_done, resp_done;

  assign req_done  = dm_req_valid_o && dm_req_ready_i;
  assign resp_done = dm_resp_valid_i && dm_resp_ready_o;

  // A new request may be accepted in the cycle its predecessor answers
  assign outstanding_d = (outstanding_q && !resp_done) || req_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      active_jtag_q <= 1'b0;
    end else begin
      outstanding_q <= outstanding_d;
      if (!outstanding_d) begin
        active_jtag_q <= src_jtag_i;
      end
    end
  end

  // -------------------------------------------------------------------
  // Routing by active source
  // -------------------------------------------------------------------
  assign dm_req_valid_o    = active_jtag_q ? jtag_req_valid_i  : dtm_req_valid_i;
  assign dm_req_o          = active_jtag_q ? jtag_req_i        : dtm_req_i;
  assign dm_resp_ready_o   = active_jtag_q ? jtag_resp_ready_i : dtm_resp_ready_i;
  assign exit_o            = active_jtag_q ? jtag_exit_i       : dtm_exit_i;
  assign jtag_resp_valid_o = active_jtag_q && dm_resp_valid_i;
  assign dtm_resp_valid_o  = !active_jtag_q && dm_resp_valid_i;

  // Debug module only answers accepted requests
  a_resp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(dm_resp_valid_i) |-> outstanding_q);

endmodule

// ==== logic/harness_top.sv ====
// ---------------------------------------------------------------------
// Harness top. The memory bus never stalls and answers one cycle after
// each request. DMI paths between sources and debug module are
// combinational apart from the source select.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module harness_top import soc_map_pkg::*, dmi_pkg::*; #(
  parameter int unsigned NumWords     = 1024,
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Memory bus
  input  logic        mem_req_i,
  input  logic        mem_we_i,
  input  addr_t       mem_addr_i,
  input  be_t         mem_be_i,
  input  data_t       mem_wdata_i,
  output data_t       mem_rdata_o,
  output logic        mem_rvalid_o,
  output logic        mem_err_o,
  // Core debug request
  input  logic        debug_req_core_i,
  output logic        debug_req_o,
  // JTAG source
  input  logic        jtag_req_valid_i,
  input  dmi_req_t    jtag_req_i,
  input  logic        jtag_resp_ready_i,
  input  logic [31:0] jtag_exit_i,
  output logic        jtag_resp_valid_o,
  // DTM source
  input  logic        dtm_req_valid_i,
  input  dmi_req_t    dtm_req_i,
  input  logic        dtm_resp_ready_i,
  input  logic [31:0] dtm_exit_i,
  output logic        dtm_resp_valid_o,
  // Debug module side
  input  logic        dm_req_ready_i,
  input  logic        dm_resp_valid_i,
  output logic        dm_req_valid_o,
  output dmi_req_t    dm_req_o,
  output logic        dm_resp_ready_o,
  output logic [31:0] exit_o
);

  localparam int unsigned SramIdxWidth = $clog2(NumWords);

  logic                    rom_req;
  logic [RomIdxWidth-1:0]  rom_idx;
  data_t                   rom_rdata;
  logic                    sram_req;
  logic                    sram_we;
  logic [SramIdxWidth-1:0] sram_idx;
  be_t                     sram_be;
  data_t                   sram_wdata;
  data_t                   sram_rdata;
  logic                    ctrl_req;
  logic                    ctrl_we;
  be_t                     ctrl_be;
  data_t                   ctrl_wdata;
  data_t                   ctrl_rdata;
  logic                    debug_en;
  logic                    src_jtag;

  // -------------------------------------------------------------------
  // Memory-mapped store
  // -------------------------------------------------------------------
  bus_decoder #(
    .NumWords ( NumWords )
  ) i_bus_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .mem_req_i    ( mem_req_i    ),
    .mem_we_i     ( mem_we_i     ),
    .mem_addr_i   ( mem_addr_i   ),
    .mem_be_i     ( mem_be_i     ),
    .mem_wdata_i  ( mem_wdata_i  ),
    .rom_rdata_i  ( rom_rdata    ),
    .sram_rdata_i ( sram_rdata   ),
    .ctrl_rdata_i ( ctrl_rdata   ),
    .rom_req_o    ( rom_req      ),
    .rom_idx_o    ( rom_idx      ),
    .sram_req_o   ( sram_req     ),
    .sram_we_o    ( sram_we      ),
    .sram_idx_o   ( sram_idx     ),
    .sram_be_o    ( sram_be      ),
    .sram_wdata_o ( sram_wdata   ),
    .ctrl_req_o   ( ctrl_req     ),
    .ctrl_we_o    ( ctrl_we      ),
    .ctrl_be_o    ( ctrl_be      ),
    .ctrl_wdata_o ( ctrl_wdata   ),
    .mem_rdata_o  ( mem_rdata_o  ),
    .mem_rvalid_o ( mem_rvalid_o ),
    .mem_err_o    ( mem_err_o    )
  );

  boot_rom i_boot_rom (
    .clk_i       ( clk_i     ),
    .rom_req_i   ( rom_req   ),
    .rom_idx_i   ( rom_idx   ),
    .rom_rdata_o ( rom_rdata )
  );

  sram_bank #(
    .NumWords ( NumWords )
  ) i_sram_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  harness_ctrl_regs i_ctrl_regs (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .req_i      ( ctrl_req   ),
    .we_i       ( ctrl_we    ),
    .be_i       ( ctrl_be    ),
    .wdata_i    ( ctrl_wdata ),
    .rdata_o    ( ctrl_rdata ),
    .debug_en_o ( debug_en   ),
    .src_jtag_o ( src_jtag   )
  );

  // -------------------------------------------------------------------
  // Debug request gate and DMI source select
  // -------------------------------------------------------------------
  debug_gate #(
    .DmiDelCycles ( DmiDelCycles )
  ) i_debug_gate (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .debug_en_i       ( debug_en         ),
    .debug_req_core_i ( debug_req_core_i ),
    .debug_req_o      ( debug_req_o      )
  );

  dmi_source_mux i_dmi_source_mux (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .src_jtag_i        ( src_jtag          ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dm_req_ready_i    ( dm_req_ready_i    ),
    .dm_resp_valid_i   ( dm_resp_valid_i   ),
    .dm_req_valid_o    ( dm_req_valid_o    ),
    .dm_req_o          ( dm_req_o          ),
    .dm_resp_ready_o   ( dm_resp_ready_o   ),
    .exit_o            ( exit_o            )
  );

endmodule

// ==== testbench/tb_checks.svh ====
// ---------------------------------------------------------------------
// Compare tasks and error counters for the harness testbench. Include
// inside a module that imports soc_map_pkg and dmi_pkg.
// ---------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_data(input string what, input data_t got, input data_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_req(input string what, input dmi_req_t got, input dmi_req_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_exit(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

// Failures that are not a wrong value
task automatic note_failure(input string msg);
  error_count++;
  $display("at %0t ns: %s", $time, msg);
endtask

`endif

// ==== testbench/tb_harness.sv ====
// ---------------------------------------------------------------------
// Testbench for harness_top. Inputs change 2 ns after the rising edge,
// outputs are sampled at the falling edge. Only SRAM words written by
// the test are read back.
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tb_harness import soc_map_pkg::*, dmi_pkg::*; ();

  localparam int unsigned NumWords     = 1024;
  localparam int unsigned DmiDelCycles = 20;
  localparam int unsigned IdxW         = $clog2(NumWords);
  // Tests take about 150 cycles
  localparam int unsigned TimeoutCycles = 3000;

  localparam addr_t UnmappedAddrs [6] = '{
    32'h4000_0000, 32'h0000_0000, 32'h1000_0000,
    32'h0001_1000, 32'h0200_0010, 32'h7fff_fff8
  };

  logic        clk_i;
  logic        rst_ni;
  logic        mem_req_i;
  logic        mem_we_i;
  addr_t       mem_addr_i;
  be_t         mem_be_i;
  data_t       mem_wdata_i;
  data_t       mem_rdata_o;
  logic        mem_rvalid_o;
  logic        mem_err_o;
  logic        debug_req_core_i;
  logic        debug_req_o;
  logic        jtag_req_valid_i;
  dmi_req_t    jtag_req_i;
  logic        jtag_resp_ready_i;
  logic [31:0] jtag_exit_i;
  logic        jtag_resp_valid_o;
  logic        dtm_req_valid_i;
  dmi_req_t    dtm_req_i;
  logic        dtm_resp_ready_i;
  logic [31:0] dtm_exit_i;
  logic        dtm_resp_valid_o;
  logic        dm_req_ready_i;
  logic        dm_resp_valid_i;
  logic        dm_req_valid_o;
  dmi_req_t    dm_req_o;
  logic        dm_resp_ready_o;
  logic [31:0] exit_o;

  // Reference state of SRAM and control word
  data_t ref_mem [NumWords];
  logic  ref_debug_en;
  logic  ref_src_jtag;

  // Expected memory responses in request order
  data_t exp_data_q [$];
  logic  exp_err_q [$];
  string exp_what_q [$];

  int   seed = 32'h963a_b473;
  int   cycle_cnt = 0;
  int   test_count = 0;
  int   errors_at_start = 0;
  logic req_seen = 1'b0;

  `include "tb_checks.svh"

  harness_top #(
    .NumWords     ( NumWords     ),
    .DmiDelCycles ( DmiDelCycles )
  ) harness_top_i (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .mem_req_i         ( mem_req_i         ),
    .mem_we_i          ( mem_we_i          ),
    .mem_addr_i        ( mem_addr_i        ),
    .mem_be_i          ( mem_be_i          ),
    .mem_wdata_i       ( mem_wdata_i       ),
    .mem_rdata_o       ( mem_rdata_o       ),
    .mem_rvalid_o      ( mem_rvalid_o      ),
    .mem_err_o         ( mem_err_o         ),
    .debug_req_core_i  ( debug_req_core_i  ),
    .debug_req_o       ( debug_req_o       ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dm_req_ready_i    ( dm_req_ready_i    ),
    .dm_resp_valid_i   ( dm_resp_valid_i   ),
    .dm_req_valid_o    ( dm_req_valid_o    ),
    .dm_req_o          ( dm_req_o          ),
    .dm_resp_ready_o   ( dm_resp_ready_o   ),
    .exit_o            ( exit_o            )
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // -------------------------------------------------------------------
  // Reference model of the memory map
  // -------------------------------------------------------------------
  function automatic void ref_read(input addr_t addr, input logic we,
                                   output data_t data, output logic err);
    addr_t off;
    data = '0;
    err  = 1'b0;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      off = (addr - RomBase) >> ByteOffset;
      if (we) begin
        err = 1'b1;
      end else if (off < 8) begin
        data = BootImage[off[2:0]];
      end
    end else if (addr >= CtrlBase && addr < CtrlBase + CtrlLength) begin
      if (!we) begin
        data[CtrlDebugEnBit] = ref_debug_en;
        data[CtrlSrcJtagBit] = ref_src_jtag;
      end
    end else if (addr >= DramBase && ((addr - DramBase) >> ByteOffset) < NumWords) begin
      off = (addr - DramBase) >> ByteOffset;
      if (!we) begin
        data = ref_mem[off[IdxW-1:0]];
      end
    end else begin
      err = 1'b1;
    end
  endfunction

  function automatic void ref_write(input addr_t addr, input be_t be, input data_t wdata);
    addr_t off;
    off = (addr - DramBase) >> ByteOffset;
    if (addr >= CtrlBase && addr < CtrlBase + CtrlLength) begin
      if (be[0]) begin
        ref_debug_en = wdata[CtrlDebugEnBit];
        ref_src_jtag = wdata[CtrlSrcJtagBit];
      end
    end else if (addr >= DramBase && off < NumWords) begin
      for (int b = 0; b < DataWidth / 8; b++) begin
        if (be[b]) begin
          ref_mem[off[IdxW-1:0]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  endfunction

  // One bus request that starts and returns 2 ns after a rising edge
  task automatic mem_access(input logic we, input addr_t addr, input be_t be,
                            input data_t wdata);
    data_t exp_data;
    logic  exp_err;
    ref_read(addr, we, exp_data, exp_err);
    if (we) begin
      ref_write(addr, be, wdata);
    end
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_what_q.push_back($sformatf("%s at %h", we ? "write" : "read", addr));
    mem_req_i   = 1'b1;
    mem_we_i    = we;
    mem_addr_i  = addr;
    mem_be_i    = be;
    mem_wdata_i = wdata;
    @(posedge clk_i);
    #2;
    mem_req_i = 1'b0;
  endtask

  task automatic bus_drain();
    repeat (2) @(posedge clk_i);
    #2;
  endtask

  task automatic finish_test(input string name);
    bus_drain();
    if (error_count == errors_at_start) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
    test_count++;
  endtask

  // Every response is due one cycle after its request
  always @(negedge clk_i) begin
    string what;
    if (rst_ni) begin
      check_flag("mem_rvalid_o", mem_rvalid_o, req_seen);
      if (mem_rvalid_o === 1'b1) begin
        if (exp_data_q.size() == 0) begin
          note_failure("memory response arrived with no request waiting for it");
        end else begin
          what = exp_what_q.pop_front();
          check_data({"rdata of ", what}, mem_rdata_o, exp_data_q.pop_front());
          check_flag({"err of ", what}, mem_err_o, exp_err_q.pop_front());
        end
      end
    end
    req_seen = rst_ni && mem_req_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------
  initial begin
    addr_t       addr;
    be_t         be;
    data_t       wdata;
    int unsigned idx;
    dmi_req_t    jtag_cmd;
    dmi_req_t    dtm_cmd;
    jtag_cmd          = '{addr: 7'h10, op: DmiWrite, data: 32'h8000_0001};
    dtm_cmd           = '{addr: 7'h11, op: DmiRead, data: 32'h0000_0000};
    rst_ni            = 1'b0;
    mem_req_i         = 1'b0;
    mem_we_i          = 1'b0;
    mem_addr_i        = '0;
    mem_be_i          = '0;
    mem_wdata_i       = '0;
    debug_req_core_i  = 1'b1;
    jtag_req_valid_i  = 1'b0;
    jtag_req_i        = '0;
    jtag_resp_ready_i = 1'b0;
    jtag_exit_i       = 32'h0000_0a5a;
    dtm_req_valid_i   = 1'b0;
    dtm_req_i         = '0;
    dtm_resp_ready_i  = 1'b0;
    dtm_exit_i        = 32'h0000_0133;
    dm_req_ready_i    = 1'b0;
    dm_resp_valid_i   = 1'b0;
    ref_debug_en      = 1'b1;
    ref_src_jtag      = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Hold-off counts rising edges after reset release
    for (int i = 0; i <= DmiDelCycles + 4; i++) begin
      @(negedge clk_i);
      check_flag($sformatf("debug_req_o after %0d edges", i), debug_req_o,
                 i >= DmiDelCycles);
      @(posedge clk_i);
      #2;
    end
    finish_test("debug_holdoff");

    for (int i = 0; i < 10; i++) begin
      mem_access(1'b0, RomBase + addr_t'(i * 8), '0, '0);
    end
    mem_access(1'b1, RomBase + 8, '1, 64'hdead_beef_0bad_f00d);
    mem_access(1'b0, RomBase + 8, '0, '0);
    finish_test("rom_reads");

    // Fill first, so partial writes never leave bytes unknown
    for (int i = 0; i < 16; i++) begin
      addr = DramBase + addr_t'(i * 8);
      mem_access(1'b1, addr, '1, {addr, ~addr});
    end
    for (int i = 0; i < 32; i++) begin
      idx   = $unsigned($random(seed)) % 16;
      be    = be_t'($random(seed));
      wdata = {$random(seed), $random(seed)};
      mem_access(1'b1, DramBase + addr_t'(idx * 8), be, wdata);
    end
    for (int i = 0; i < 16; i++) begin
      mem_access(1'b0, DramBase + addr_t'(i * 8), '0, '0);
    end
    addr = DramBase + addr_t'((NumWords - 1) * 8);
    mem_access(1'b1, addr, '1, {addr, ~addr});
    mem_access(1'b0, addr, '0, '0);
    mem_access(1'b1, DramBase + addr_t'(NumWords * 8), '1, 64'h1234_5678_9abc_def0);
    mem_access(1'b0, DramBase + addr_t'(NumWords * 8), '0, '0);
    finish_test("sram_rw");

    foreach (UnmappedAddrs[i]) begin
      mem_access(1'b0, UnmappedAddrs[i], '0, '0);
    end
    mem_access(1'b1, UnmappedAddrs[0], '1, 64'h0000_0000_ffff_ffff);
    finish_test("unmapped");

    @(negedge clk_i);
    check_flag("debug_req_o while enabled", debug_req_o, 1'b1);
    @(posedge clk_i);
    #2;
    mem_access(1'b0, CtrlBase, '0, '0);
    mem_access(1'b1, CtrlBase, 8'h01, 64'h0);
    @(negedge clk_i);
    check_flag("debug_req_o after disable", debug_req_o, 1'b0);
    @(posedge clk_i);
    #2;
    mem_access(1'b0, CtrlBase + 8, '0, '0);
    finish_test("debug_disable");

    // DTM request accepted, then JTAG selected while it is outstanding
    dtm_req_valid_i  = 1'b1;
    dtm_req_i        = dtm_cmd;
    jtag_req_i       = jtag_cmd;
    dm_req_ready_i   = 1'b1;
    @(negedge clk_i);
    check_flag("dm_req_valid_o from DTM", dm_req_valid_o, 1'b1);
    check_req("dm_req_o from DTM", dm_req_o, dtm_cmd);
    check_exit("exit_o from DTM", exit_o, dtm_exit_i);
    @(posedge clk_i);
    #2;
    dtm_req_valid_i  = 1'b0;
    jtag_req_valid_i = 1'b1;
    dm_req_ready_i   = 1'b0;
    mem_access(1'b1, CtrlBase, 8'h01, 64'h2);
    @(negedge clk_i);
    check_flag("dm_req_valid_o while outstanding", dm_req_valid_o, 1'b0);
    check_req("dm_req_o while outstanding", dm_req_o, dtm_cmd);
    check_exit("exit_o while outstanding", exit_o, dtm_exit_i);
    @(posedge clk_i);
    #2;
    dm_resp_valid_i  = 1'b1;
    dtm_resp_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("dtm_resp_valid_o", dtm_resp_valid_o, 1'b1);
    check_flag("jtag_resp_valid_o", jtag_resp_valid_o, 1'b0);
    check_flag("dm_resp_ready_o", dm_resp_ready_o, 1'b1);
    @(posedge clk_i);
    #2;
    dm_resp_valid_i  = 1'b0;
    dtm_resp_ready_i = 1'b0;
    @(negedge clk_i);
    check_flag("dm_req_valid_o from JTAG", dm_req_valid_o, 1'b1);
    check_req("dm_req_o from JTAG", dm_req_o, jtag_cmd);
    check_exit("exit_o from JTAG", exit_o, jtag_exit_i);
    @(posedge clk_i);
    #2;
    // Full JTAG transaction with no response to DTM
    dm_req_ready_i = 1'b1;
    @(posedge clk_i);
    #2;
    jtag_req_valid_i  = 1'b0;
    dm_req_ready_i    = 1'b0;
    dm_resp_valid_i   = 1'b1;
    jtag_resp_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("jtag_resp_valid_o after switch", jtag_resp_valid_o, 1'b1);
    check_flag("dtm_resp_valid_o after switch", dtm_resp_valid_o, 1'b0);
    @(posedge clk_i);
    #2;
    dm_resp_valid_i   = 1'b0;
    jtag_resp_ready_i = 1'b0;
    finish_test("source_switch");

    if (exp_data_q.size() != 0) begin
      note_failure($sformatf("%0d memory requests never got a response",
                             exp_data_q.size()));
    end
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+testbench
logic/soc_map_pkg.sv
logic/dmi_pkg.sv
logic/boot_rom.sv
logic/sram_bank.sv
logic/harness_ctrl_regs.sv
logic/bus_decoder.sv
logic/debug_gate.sv
logic/dmi_source_mux.sv
logic/harness_top.sv
testbench/tb_harness.sv

// ==== Makefile ====
TOP := tb_harness

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o sim_$(TOP)

# The pass line in the log decides the result, not the simulator status
run: compile
	./obj_dir/sim_$(TOP) | tee run.log
	grep -q "RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log
